/* Makefile */
SIM      = verilator
TOP      = rtf_nimplus_tb
FILELIST = all.f
FLAGS    = --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^=== PASS ===$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* all.f */
design/nimplus_pkg.sv
design/param_regs.sv
design/pulse_gen.sv
design/output_router.sv
design/rtf_nimplus.sv
sim/rtf_nimplus_tb.sv

/* design/nimplus_pkg.sv */
package nimplus_pkg;

   // Bus word types
   typedef logic [7:0]  reg_addr_t;   // Register address
   typedef logic [31:0] reg_data_t;   // Register word
   typedef logic [7:0]  src_sel_t;    // Mux selection code

   // Input side counts
   localparam int N_NIM_IN  = 8;
   localparam int N_LVDS_IN = 4;
   localparam int N_PULSE   = 2;      // Pulse generators
   localparam int N_RJ45_IN = 8;      // Per back-panel RJ45
   localparam int N_SMA     = 2;      // SMA inputs and SMA outputs

   // Output side counts
   localparam int N_NIM_OUT  = 4;
   localparam int N_RJ45_OUT = 12;    // Per front-panel RJ45
   localparam int N_MUX      = N_NIM_OUT + 2*N_RJ45_OUT + N_SMA;      // 30 channels

   // Selectable source counts
   localparam int N_LOCAL_SRC = N_NIM_IN + N_LVDS_IN + N_PULSE;       // NIM outputs only
   localparam int N_ALL_SRC   = N_LOCAL_SRC + 2*N_RJ45_IN + N_SMA;    // RJ45 and SMA outputs

   localparam int LEN_WIDTH = 6;      // Pulse length field

   // Source index layout
   localparam int SRC_NIM_BASE    = 0;
   localparam int SRC_LVDS_BASE   = SRC_NIM_BASE + N_NIM_IN;          // 8
   localparam int SRC_PULSE_BASE  = SRC_LVDS_BASE + N_LVDS_IN;        // 12
   localparam int SRC_RJ45_1_BASE = SRC_PULSE_BASE + N_PULSE;         // 14
   localparam int SRC_RJ45_2_BASE = SRC_RJ45_1_BASE + N_RJ45_IN;      // 22
   localparam int SRC_SMA_BASE    = SRC_RJ45_2_BASE + N_RJ45_IN;      // 30

   // Mux channel layout
   localparam int MUX_NIM_BASE    = 0;
   localparam int MUX_RJ45_1_BASE = MUX_NIM_BASE + N_NIM_OUT;         // 4
   localparam int MUX_RJ45_2_BASE = MUX_RJ45_1_BASE + N_RJ45_OUT;     // 16
   localparam int MUX_SMA_BASE    = MUX_RJ45_2_BASE + N_RJ45_OUT;     // 28

   // Address map
   typedef enum logic [7:0]
   {
      REG_CTRL     = 8'd0,            // Soft reset in bit 0
      REG_PULSE0   = 8'd1,
      REG_PULSE1   = 8'd2,
      REG_MUX_BASE = 8'd16            // Mux channel n sits at 16 + n
   } reg_map_e;

   // Field positions inside a register word
   localparam int CTRL_SOFT_RST_BIT = 0;
   localparam int PULSE_LEN_LSB     = 16;   // Period occupies the bits below
   localparam int MUX_INV_BIT       = 8;    // Selection in 7:0

   // Register defaults
   // Pulses off, every channel on source 0 and not inverted
   localparam int                   DEF_PULSE_PERIOD = 0;
   localparam logic [LEN_WIDTH-1:0] DEF_PULSE_LENGTH = '0;
   localparam src_sel_t             DEF_MUX_SEL      = '0;
   localparam logic                 DEF_MUX_INVERT   = 1'b0;

endpackage

/* design/output_router.sv */
`timescale 1ns/1ps

module output_router
   import nimplus_pkg::*;
(
   input  logic                  clk_160,
   input  logic                  rst,
   input  logic [N_ALL_SRC-1:0]  sources,           // Packed in source index order
   input  src_sel_t              mux_sel [N_MUX],
   input  logic [N_MUX-1:0]      mux_invert,        // Applied on NIM channels only
   output logic [N_NIM_OUT-1:0]  nim_out,
   output logic [N_RJ45_OUT-1:0] rj45_out_1,
   output logic [N_RJ45_OUT-1:0] rj45_out_2,
   output logic [N_SMA-1:0]      sma_out
);

   localparam int SRC_IDX_W = $clog2(N_ALL_SRC);

   logic [N_MUX-1:0] mux_val;                       // Next value per channel

   // One source bit, zero when the code is beyond the allowed range
   function automatic logic pick(src_sel_t sel, int limit);
      logic val;
      val = 1'b0;
      if (int'(sel) < limit)
         val = sources[sel[SRC_IDX_W-1:0]];
      return val;
   endfunction

   always_comb
   begin
      for (int ch = 0; ch < N_MUX; ch++)
      begin
         if (ch < MUX_RJ45_1_BASE)
            mux_val[ch] = mux_invert[ch] ^ pick(mux_sel[ch], N_LOCAL_SRC);  // NIM
         else
            mux_val[ch] = pick(mux_sel[ch], N_ALL_SRC);   // RJ45 and SMA, no invert
      end
   end

   // Output register stage
   always_ff @(posedge clk_160)
   begin
      if (rst)
      begin
         nim_out    <= '0;
         rj45_out_1 <= '0;
         rj45_out_2 <= '0;
         sma_out    <= '0;
      end
      else
      begin
         nim_out    <= mux_val[MUX_NIM_BASE +: N_NIM_OUT];     // Channel n to NIM n
         rj45_out_1 <= mux_val[MUX_RJ45_1_BASE +: N_RJ45_OUT];
         rj45_out_2 <= mux_val[MUX_RJ45_2_BASE +: N_RJ45_OUT];
         sma_out    <= mux_val[MUX_SMA_BASE +: N_SMA];
      end
   end

   // Front panel stays quiet right after a reset
   a_outputs_reset: assert property (@(posedge clk_160)
      $past(rst) |-> (nim_out == '0 && rj45_out_1 == '0 &&
                      rj45_out_2 == '0 && sma_out == '0))
      else $error("router outputs not low after rst");

endmodule

/* design/param_regs.sv */
`timescale 1ns/1ps

module param_regs
   import nimplus_pkg::*;
#(
   parameter int PERIOD_WIDTH = 16                  // Pulse period field width
)
(
   input  logic                    clk_160,
   input  logic                    rst,
   // Register strobe bus
   input  reg_addr_t               reg_addr,
   input  reg_data_t               reg_wdata,
   input  logic                    reg_we,          // Single-cycle write strobe
   input  logic                    reg_re,          // Single-cycle read strobe
   output reg_data_t               reg_rdata,
   output logic                    reg_rack,        // One cycle after reg_re
   output logic                    soft_rst,        // Self clearing
   // Pulse generator fields
   output logic [PERIOD_WIDTH-1:0] pulse_period [N_PULSE],
   output logic [LEN_WIDTH-1:0]    pulse_length [N_PULSE],
   // Router fields
   output src_sel_t                mux_sel [N_MUX],
   output logic [N_MUX-1:0]        mux_invert
);

   localparam int MUX_IDX_W = $clog2(N_MUX);

   logic                 sel_ctrl;        // Address hits REG_CTRL
   logic [N_PULSE-1:0]   sel_pulse;       // One hot per generator
   logic                 sel_mux;         // Address inside the mux window
   reg_addr_t            mux_off;
   logic [MUX_IDX_W-1:0] mux_idx;
   reg_data_t            rd_word;         // Read word before the output register

   // Mux window offset, addresses below the base wrap high and miss
   assign mux_off = reg_addr - REG_MUX_BASE;
   assign mux_idx = mux_off[MUX_IDX_W-1:0];
   assign sel_mux = (mux_off < reg_addr_t'(N_MUX));

   always_comb
   begin
      sel_ctrl  = 1'b0;
      sel_pulse = '0;
      case (reg_addr)
         REG_CTRL:   sel_ctrl     = 1'b1;
         REG_PULSE0: sel_pulse[0] = 1'b1;
         REG_PULSE1: sel_pulse[1] = 1'b1;
         default:    ;                      // Mux window or unmapped
      endcase
   end

   // Field storage
   always_ff @(posedge clk_160)
   begin
      if (rst || soft_rst)                  // Either one restores defaults
      begin
         for (int p = 0; p < N_PULSE; p++)
         begin
            pulse_period[p] <= PERIOD_WIDTH'(DEF_PULSE_PERIOD);
            pulse_length[p] <= DEF_PULSE_LENGTH;
         end
         for (int ch = 0; ch < N_MUX; ch++)
         begin
            mux_sel[ch]    <= DEF_MUX_SEL;
            mux_invert[ch] <= DEF_MUX_INVERT;
         end
      end
      else if (reg_we)
      begin
         for (int p = 0; p < N_PULSE; p++)
         begin
            if (sel_pulse[p])
            begin
               pulse_period[p] <= reg_wdata[PERIOD_WIDTH-1:0];
               pulse_length[p] <= reg_wdata[PULSE_LEN_LSB +: LEN_WIDTH];
            end
         end
         if (sel_mux)
         begin
            mux_sel[mux_idx]    <= reg_wdata[$bits(src_sel_t)-1:0];
            mux_invert[mux_idx] <= reg_wdata[MUX_INV_BIT];
         end
      end
   end

   // Read word rebuilt from stored fields
   always_comb
   begin
      rd_word = '0;                         // CTRL and unmapped read zero
      for (int p = 0; p < N_PULSE; p++)
      begin
         if (sel_pulse[p])
         begin
            rd_word[PERIOD_WIDTH-1:0]           = pulse_period[p];
            rd_word[PULSE_LEN_LSB +: LEN_WIDTH] = pulse_length[p];
         end
      end
      if (sel_mux)
      begin
         rd_word[$bits(src_sel_t)-1:0] = mux_sel[mux_idx];
         rd_word[MUX_INV_BIT]          = mux_invert[mux_idx];
      end
   end

   // Read response and soft reset pulse
   always_ff @(posedge clk_160)
   begin
      if (rst)
      begin
         soft_rst  <= 1'b0;
         reg_rack  <= 1'b0;
         reg_rdata <= '0;
      end
      else
      begin
         // Blocked while already high so it never stretches
         soft_rst <= reg_we && sel_ctrl && reg_wdata[CTRL_SOFT_RST_BIT] && !soft_rst;
         reg_rack <= reg_re;
         if (reg_re)
            reg_rdata <= rd_word;           // Held until the next read
      end
   end

   // Bus master must not overlap strobes
   a_bus_exclusive: assert property (@(posedge clk_160) disable iff (rst)
      !(reg_we && reg_re))
      else $error("reg_we and reg_re high together");

   a_rack_follows: assert property (@(posedge clk_160) disable iff (rst)
      reg_re |=> reg_rack)
      else $error("reg_rack missing after reg_re");

   a_rack_only_after_re: assert property (@(posedge clk_160) disable iff (rst)
      reg_rack |-> $past(reg_re))
      else $error("reg_rack without reg_re");

   a_soft_rst_single: assert property (@(posedge clk_160) disable iff (rst)
      soft_rst |=> !soft_rst)
      else $error("soft_rst longer than one cycle");

endmodule

/* design/pulse_gen.sv */
`timescale 1ns/1ps

module pulse_gen
   import nimplus_pkg::*;
#(
   parameter int PERIOD_WIDTH = 16                  // Counter and period width
)
(
   input  logic                    clk_160,
   input  logic                    rst,
   input  logic                    soft_rst,        // Clears the counter like rst
   input  logic [PERIOD_WIDTH-1:0] period,          // Zero disables
   input  logic [LEN_WIDTH-1:0]    length,          // High cycles per period
   output logic                    pulse
);

   logic [PERIOD_WIDTH-1:0] count;                  // Free running phase
   logic                    wrap;
   logic                    period_off;

   assign period_off = (period == '0);

   // Also wraps when a smaller period leaves the counter beyond the end
   assign wrap = period_off || (count >= period - 1'b1);

   always_ff @(posedge clk_160)
   begin
      if (rst || soft_rst)
      begin
         count <= '0;
         pulse <= 1'b0;
      end
      else
      begin
         if (wrap)
            count <= '0;                            // Holds 0 while period is 0
         else
            count <= count + 1'b1;
         // High for counter values below the length
         pulse <= !period_off && (count < PERIOD_WIDTH'(length));
      end
   end

   // A disabled generator gives a low output one cycle on
   a_off_is_low: assert property (@(posedge clk_160) disable iff (rst)
      $past(period_off) |-> !pulse)
      else $error("pulse high with period 0");

endmodule

/* design/rtf_nimplus.sv */
`timescale 1ns/1ps

module rtf_nimplus
   import nimplus_pkg::*;
#(
   parameter int PERIOD_WIDTH = 16                  // Pulse period width
)
(
   input  logic                  clk_160,
   input  logic                  rst,
   // Front and back panel inputs
   input  logic [N_NIM_IN-1:0]   nim_in,
   input  logic [N_LVDS_IN-1:0]  lvds_in,
   input  logic [N_RJ45_IN-1:0]  rj45_in_1,         // Back panel RJ45 1
   input  logic [N_RJ45_IN-1:0]  rj45_in_2,         // Back panel RJ45 2
   input  logic [N_SMA-1:0]      sma_in,
   // Register strobe bus
   input  reg_addr_t             reg_addr,
   input  reg_data_t             reg_wdata,
   input  logic                  reg_we,
   input  logic                  reg_re,
   output reg_data_t             reg_rdata,
   output logic                  reg_rack,
   // Panel outputs
   output logic [N_NIM_OUT-1:0]  nim_out,
   output logic [N_RJ45_OUT-1:0] rj45_out_1,        // Front panel RJ45 1
   output logic [N_RJ45_OUT-1:0] rj45_out_2,        // Front panel RJ45 2
   output logic [N_SMA-1:0]      sma_out
);

   logic                    soft_rst;
   logic [PERIOD_WIDTH-1:0] pulse_period [N_PULSE];
   logic [LEN_WIDTH-1:0]    pulse_length [N_PULSE];
   src_sel_t                mux_sel [N_MUX];
   logic [N_MUX-1:0]        mux_invert;
   logic [N_PULSE-1:0]      pulse;
   logic [N_ALL_SRC-1:0]    sources;               // Router source vector

   // Source vector in package index order
   assign sources[SRC_NIM_BASE +: N_NIM_IN]     = nim_in;
   assign sources[SRC_LVDS_BASE +: N_LVDS_IN]   = lvds_in;
   assign sources[SRC_PULSE_BASE +: N_PULSE]    = pulse;
   assign sources[SRC_RJ45_1_BASE +: N_RJ45_IN] = rj45_in_1;
   assign sources[SRC_RJ45_2_BASE +: N_RJ45_IN] = rj45_in_2;
   assign sources[SRC_SMA_BASE +: N_SMA]        = sma_in;

   param_regs #(.PERIOD_WIDTH(PERIOD_WIDTH)) param_regs_i
   (
      .clk_160      (clk_160),
      .rst          (rst),
      .reg_addr     (reg_addr),
      .reg_wdata    (reg_wdata),
      .reg_we       (reg_we),
      .reg_re       (reg_re),
      .reg_rdata    (reg_rdata),
      .reg_rack     (reg_rack),
      .soft_rst     (soft_rst),
      .pulse_period (pulse_period),
      .pulse_length (pulse_length),
      .mux_sel      (mux_sel),
      .mux_invert   (mux_invert)
   );

   // One generator per pulse register
   for (genvar g = 0; g < N_PULSE; g++)
   begin : g_pulse
      pulse_gen #(.PERIOD_WIDTH(PERIOD_WIDTH)) pulse_gen_i
      (
         .clk_160  (clk_160),
         .rst      (rst),
         .soft_rst (soft_rst),
         .period   (pulse_period[g]),
         .length   (pulse_length[g]),
         .pulse    (pulse[g])
      );
   end

   output_router output_router_i
   (
      .clk_160    (clk_160),
      .rst        (rst),
      .sources    (sources),
      .mux_sel    (mux_sel),
      .mux_invert (mux_invert),
      .nim_out    (nim_out),
      .rj45_out_1 (rj45_out_1),
      .rj45_out_2 (rj45_out_2),
      .sma_out    (sma_out)
   );

endmodule

/* sim/rtf_nimplus_tb.sv */
`timescale 1ns/1ps

module rtf_nimplus_tb
   import nimplus_pkg::*;
();

   localparam int PERIOD_WIDTH = 16;
   localparam int WAIT_LIMIT   = 4000;          // Cycles before a wait gives up

   logic                  clk_160 = 1'b0;
   logic                  rst;
   logic [N_NIM_IN-1:0]   nim_in;
   logic [N_LVDS_IN-1:0]  lvds_in;
   logic [N_RJ45_IN-1:0]  rj45_in_1;
   logic [N_RJ45_IN-1:0]  rj45_in_2;
   logic [N_SMA-1:0]      sma_in;
   reg_addr_t             reg_addr;
   reg_data_t             reg_wdata;
   logic                  reg_we;
   logic                  reg_re;
   reg_data_t             reg_rdata;
   logic                  reg_rack;
   logic [N_NIM_OUT-1:0]  nim_out;
   logic [N_RJ45_OUT-1:0] rj45_out_1;
   logic [N_RJ45_OUT-1:0] rj45_out_2;
   logic [N_SMA-1:0]      sma_out;

   // Reference copy of the stored fields, kept from issued writes
   src_sel_t                ref_sel [N_MUX];
   logic [N_MUX-1:0]        ref_inv;
   logic [PERIOD_WIDTH-1:0] ref_period [N_PULSE];
   logic [LEN_WIDTH-1:0]    ref_len [N_PULSE];
   reg_data_t               exp_rdata;       // Word due with the next reg_rack

   logic [31:0]          lfsr = 32'ha6fa;
   int                   errors = 0;
   int                   timeouts = 0;
   int                   hold = 0;             // Settling cycles after a write
   logic                 inputs_live = 1'b0;   // Fresh random inputs every cycle
   logic                 route_on = 1'b0;
   logic                 pulse_on = 1'b0;
   logic                 idle_on = 1'b0;
   logic [N_ALL_SRC-1:0] src_vec;
   logic [N_MUX-1:0]     out_vec;
   logic [N_MUX-1:0]     route_exp;            // Output values due one cycle later
   logic [3:0]           mon;
   logic [3:0]           mon_q;
   int                   run_len [4];
   int                   edges [4];

   always #5 clk_160 = ~clk_160;                // 160 MHz stand-in, 10 ns period

   rtf_nimplus #(.PERIOD_WIDTH(PERIOD_WIDTH)) rtf_nimplus_i (.*);

   // Pulse sources left at 0, routing is only checked with both periods at 0
   assign src_vec = {sma_in, rj45_in_2, rj45_in_1, 2'b00, lvds_in, nim_in};
   assign out_vec = {sma_out, rj45_out_2, rj45_out_1, nim_out};   // Channel order
   // Pulse 0 on mon 0 and 2, pulse 1 on mon 1 and 3
   assign mon     = {rj45_out_2[0], rj45_out_1[0], nim_out[1], nim_out[0]};

   always_comb
   begin
      for (int ch = 0; ch < N_MUX; ch++)
      begin
         if (ch < N_NIM_OUT)                    // Local sources, invert applies
            route_exp[ch] = ref_inv[ch] ^
                            (int'(ref_sel[ch]) < N_LOCAL_SRC && src_vec[ref_sel[ch][4:0]]);
         else
            route_exp[ch] = int'(ref_sel[ch]) < N_ALL_SRC && src_vec[ref_sel[ch][4:0]];
      end
   end

   always_ff @(posedge clk_160)
   begin
      if (reg_we)
         hold <= 3;                             // Field, pulse and output stages
      else if (hold > 0)
         hold <= hold - 1;
   end

   // Run length tracking on the routed pulse outputs
   always_ff @(posedge clk_160)
   begin
      mon_q <= mon;
      for (int m = 0; m < 4; m++)
      begin
         if (!pulse_on)
         begin
            edges[m]   <= 0;
            run_len[m] <= 0;
         end
         else if (mon[m] != mon_q[m])
         begin
            edges[m]   <= edges[m] + 1;
            run_len[m] <= 1;                    // First cycle of the new level
         end
         else
            run_len[m] <= run_len[m] + 1;
      end
   end

   a_rack_after_re: assert property (@(posedge clk_160) disable iff (rst)
      reg_re |=> reg_rack)
      else begin
         errors++;
         $display("ERROR %0t: no reg_rack after reg_re", $time);
      end

   a_rack_needs_re: assert property (@(posedge clk_160) disable iff (rst)
      reg_rack |-> $past(reg_re))
      else begin
         errors++;
         $display("ERROR %0t: reg_rack without reg_re", $time);
      end

   a_read_data: assert property (@(posedge clk_160) disable iff (rst)
      reg_rack |-> reg_rdata == exp_rdata)
      else begin
         errors++;
         $display("ERROR %0t: read of address %0d gave %h, expected %h", $time,
                  reg_addr, $sampled(reg_rdata), $sampled(exp_rdata));
      end

   a_routing: assert property (@(posedge clk_160) disable iff (rst)
      (route_on && hold == 0) |-> out_vec == $past(route_exp))
      else begin
         errors++;
         $display("ERROR %0t: outputs %h, expected %h", $time,
                  $sampled(out_vec), $past(route_exp));
      end

   a_pulse_idle: assert property (@(posedge clk_160) disable iff (rst)
      (idle_on && hold == 0) |-> (nim_out[1:0] == ref_inv[1:0] &&
                                  rj45_out_1[0] == 1'b0 && rj45_out_2[0] == 1'b0))
      else begin
         errors++;
         $display("ERROR %0t: idle pulse output not at rest", $time);
      end

   for (genvar m = 0; m < 4; m++)
   begin : g_runs
      a_run_length: assert property (@(posedge clk_160) disable iff (rst)
         (pulse_on && hold == 0 && mon[m] != mon_q[m] && edges[m] >= 2) |->
            run_len[m] == (mon_q[m] ? int'(ref_len[m % 2]) :
                           int'(ref_period[m % 2]) - int'(ref_len[m % 2])))
         else begin
            errors++;
            $display("ERROR %0t: monitor %0d level %0b ran %0d cycles", $time, m,
                     $sampled(mon_q[m]), $sampled(run_len[m]));
         end
   end

   // Galois LFSR, one step per bit taken
   function automatic logic [31:0] rand_bits(int n);
      logic [31:0] val;
      val = '0;
      for (int i = 0; i < n; i++)
      begin
         val  = {val[30:0], lfsr[0]};
         lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h80200003 : 32'h0);
      end
      return val;
   endfunction

   function automatic void clear_model();
      ref_inv = '0;
      for (int ch = 0; ch < N_MUX; ch++)
         ref_sel[ch] = '0;
      for (int g = 0; g < N_PULSE; g++)
      begin
         ref_period[g] = '0;
         ref_len[g]    = '0;
      end
   endfunction

   function automatic void update_model(reg_addr_t addr, reg_data_t data);
      int off;
      off = int'(addr) - int'(REG_MUX_BASE);
      if (addr == REG_CTRL && data[0])
         clear_model();                         // Soft reset
      else if (addr == REG_PULSE0 || addr == REG_PULSE1)
      begin
         ref_period[int'(addr) - 1] = data[15:0];
         ref_len[int'(addr) - 1]    = data[21:16];
      end
      else if (off >= 0 && off < N_MUX)
      begin
         ref_sel[off] = data[7:0];
         ref_inv[off] = data[8];
      end
   endfunction

   // Stored fields only, everything else zero
   function automatic reg_data_t expected_word(reg_addr_t addr);
      reg_data_t w;
      int        off;
      w   = '0;
      off = int'(addr) - int'(REG_MUX_BASE);
      if (addr == REG_PULSE0 || addr == REG_PULSE1)
      begin
         w[15:0]  = ref_period[int'(addr) - 1];
         w[21:16] = ref_len[int'(addr) - 1];
      end
      else if (off >= 0 && off < N_MUX)
      begin
         w[7:0] = ref_sel[off];
         w[8]   = ref_inv[off];
      end
      return w;
   endfunction

   task automatic step_cycle();
      logic [31:0] r;
      @(posedge clk_160);
      if (inputs_live)
      begin
         r = rand_bits(N_NIM_IN + N_LVDS_IN + N_SMA);
         nim_in  <= r[0 +: N_NIM_IN];
         lvds_in <= r[N_NIM_IN +: N_LVDS_IN];
         sma_in  <= r[N_NIM_IN + N_LVDS_IN +: N_SMA];
         r = rand_bits(2 * N_RJ45_IN);
         rj45_in_1 <= r[0 +: N_RJ45_IN];
         rj45_in_2 <= r[N_RJ45_IN +: N_RJ45_IN];
      end
   endtask

   task automatic write_reg(reg_addr_t addr, reg_data_t data);
      step_cycle();
      reg_addr  <= addr;
      reg_wdata <= data;
      reg_we    <= 1'b1;
      update_model(addr, data);
      step_cycle();
      reg_we <= 1'b0;
   endtask

   task automatic read_reg(reg_addr_t addr);
      int n;
      step_cycle();
      reg_addr  <= addr;
      reg_re    <= 1'b1;
      exp_rdata <= expected_word(addr);
      step_cycle();
      reg_re <= 1'b0;
      n = 0;
      do
      begin
         @(negedge clk_160);
         n++;
      end
      while (!reg_rack && n < WAIT_LIMIT);
      if (!reg_rack)
      begin
         timeouts++;
         $display("Timeout at %0t: no read acknowledge for address %0d", $time, addr);
      end
   endtask

   task automatic read_all_regs();
      read_reg(REG_CTRL);
      read_reg(REG_PULSE0);
      read_reg(REG_PULSE1);
      for (int ch = 0; ch < N_MUX; ch++)
         read_reg(reg_addr_t'(int'(REG_MUX_BASE) + ch));
   endtask

   // Random period and a length strictly inside it
   task automatic program_pulses();
      int per;
      int len;
      int lim;
      for (int g = 0; g < N_PULSE; g++)
      begin
         per = 2 + int'(rand_bits(6));
         lim = (per - 1 > 63) ? 63 : per - 1;
         len = 1 + int'(rand_bits(6)) % lim;
         write_reg(reg_addr_t'(int'(REG_PULSE0) + g), {10'b0, 6'(len), 16'(per)});
      end
   endtask

   task automatic route_pulses(logic inv0, logic inv1);
      write_reg(REG_MUX_BASE, {23'b0, inv0, 8'(SRC_PULSE_BASE)});
      write_reg(reg_addr_t'(int'(REG_MUX_BASE) + 1), {23'b0, inv1, 8'(SRC_PULSE_BASE + 1)});
      write_reg(reg_addr_t'(int'(REG_MUX_BASE) + MUX_RJ45_1_BASE), 32'(SRC_PULSE_BASE));
      write_reg(reg_addr_t'(int'(REG_MUX_BASE) + MUX_RJ45_2_BASE), 32'(SRC_PULSE_BASE + 1));
   endtask

   initial
   begin
      reg_data_t   w;
      reg_addr_t   a;
      logic [31:0] r;
      int          n;
      rst       = 1'b1;
      nim_in    = '0;
      lvds_in   = '0;
      rj45_in_1 = '0;
      rj45_in_2 = '0;
      sma_in    = '0;
      reg_addr  = '0;
      reg_wdata = '0;
      reg_we    = 1'b0;
      reg_re    = 1'b0;
      exp_rdata = '0;
      clear_model();
      for (int i = 0; i < 10; i++)
         step_cycle();
      rst <= 1'b0;

      read_all_regs();                          // Defaults after rst

      // Every mapped address, then random ones incl. unmapped
      for (int i = 0; i < 2 + N_MUX; i++)
      begin
         a = (i < 2) ? reg_addr_t'(i + 1) : reg_addr_t'(int'(REG_MUX_BASE) + i - 2);
         write_reg(a, rand_bits(32));
         read_reg(a);
      end
      for (int i = 0; i < 24; i++)
      begin
         a = reg_addr_t'(rand_bits(8));
         w = rand_bits(32);
         if (a == REG_CTRL)
            w[0] = 1'b0;                        // Keep soft reset out of this loop
         write_reg(a, w);
         read_reg(a);
      end

      write_reg(REG_CTRL, rand_bits(32) | 32'h1);
      read_all_regs();

      // Random routing with live inputs
      inputs_live = 1'b1;
      route_on <= 1'b1;
      for (int round = 0; round < 4; round++)
      begin
         for (int ch = 0; ch < N_MUX; ch++)
         begin
            r = rand_bits(7);                   // Invert and a 6-bit select
            write_reg(reg_addr_t'(int'(REG_MUX_BASE) + ch), {23'b0, r[6], 2'b00, r[5:0]});
         end
         for (int i = 0; i < 24; i++)
            step_cycle();
      end
      route_on <= 1'b0;
      inputs_live = 1'b0;

      // Pulse run lengths on NIM and RJ45 outputs
      for (int round = 0; round < 3; round++)
      begin
         pulse_on <= 1'b0;
         program_pulses();
         route_pulses(1'b0, 1'b0);
         for (int i = 0; i < 4; i++)
            step_cycle();
         pulse_on <= 1'b1;
         n = 0;
         while ((edges[0] < 10 || edges[1] < 10 || edges[2] < 10 || edges[3] < 10) &&
                n < WAIT_LIMIT)
         begin
            @(negedge clk_160);
            n++;
         end
         if (n >= WAIT_LIMIT)
         begin
            timeouts++;
            $display("Timeout at %0t: pulse outputs stopped toggling", $time);
         end
      end
      pulse_on <= 1'b0;

      // Period 0 rests at the invert value
      write_reg(REG_PULSE0, {10'b0, 6'(rand_bits(6)), 16'b0});
      write_reg(REG_PULSE1, {10'b0, 6'(rand_bits(6)), 16'b0});
      r = rand_bits(2);
      route_pulses(r[0], r[1]);
      idle_on <= 1'b1;
      for (int i = 0; i < 40; i++)
         step_cycle();
      idle_on <= 1'b0;

      // Soft reset with pulses running
      program_pulses();
      write_reg(REG_CTRL, 32'h1);
      read_all_regs();
      route_pulses(1'b0, 1'b0);
      idle_on <= 1'b1;
      for (int i = 0; i < 40; i++)
         step_cycle();
      idle_on <= 1'b0;
      step_cycle();

      $display("Checks done with %0d errors and %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule
